//--- Bender.yml
package:
  name: input_ports

sources:
  - common/noc_pkg.sv
  - common/flit_pkg.sv
  - hdl/fwft_fifo.sv
  - input_queue/flit_buffer.sv
  - input_queue/look_ahead_xy_route.sv
  - input_queue/ivc_control.sv
  - input_queue/header_update.sv
  - input_queue/input_queue_per_port.sv
  - hdl/input_ports.sv
  - target: simulation
    files:
      - tb/tb_input_ports.sv

//--- common/flit_pkg.sv
`default_nettype none

package flit_pkg;

    typedef struct packed {
        logic                             hdr;
        logic                             tail;
        noc_pkg::vc_mask_t                vc;
        logic [noc_pkg::PAYLOAD_W-1:0]    payload;
    } flit_t;

    // header payload layout, msb first
    typedef struct packed {
        noc_pkg::class_t       class_id;
        noc_pkg::port_num_t    dest_port;   // output port at this router
        noc_pkg::router_addr_t dest_addr;
        noc_pkg::router_addr_t src_addr;
        logic [19:0]           data;
    } hdr_fields_t;

    // allocator side of one input port
    typedef struct packed {
        noc_pkg::vc_mask_t                           ivc_grant;   // one hot or zero
        noc_pkg::vc_mask_t                           reset_ivc;
        noc_pkg::vc_mask_t [noc_pkg::NUM_VCS-1:0]    assigned_ovc;
    } sw_ctrl_t;

    typedef struct packed {
        logic                  request;
        logic                  tail;
        noc_pkg::port_mask_t   dest_port;
        noc_pkg::vc_mask_t     candidate_ovcs;
    } ivc_status_t;

endpackage

`default_nettype wire

//--- common/noc_pkg.sv
`default_nettype none

package noc_pkg;

    // mesh geometry
    localparam int NUM_PORTS   = 5;
    localparam int NUM_VCS     = 4;
    localparam int VC_DEPTH    = 4;   // flits per vc
    localparam int MESH_X      = 4;
    localparam int MESH_Y      = 4;
    localparam int COORD_W     = $clog2((MESH_X > MESH_Y) ? MESH_X : MESH_Y);
    localparam int NUM_CLASSES = 2;
    localparam int PAYLOAD_W   = 32;

    typedef logic [2:0] port_num_t;

    // port numbering, x grows east, y grows south
    localparam port_num_t PORT_LOCAL = 3'd0;
    localparam port_num_t PORT_EAST  = 3'd1;
    localparam port_num_t PORT_NORTH = 3'd2;
    localparam port_num_t PORT_WEST  = 3'd3;
    localparam port_num_t PORT_SOUTH = 3'd4;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } router_addr_t;

    typedef logic [NUM_VCS-1:0]   vc_mask_t;
    typedef logic [NUM_PORTS-2:0] port_mask_t;   // own port squeezed out
    typedef logic [$clog2(NUM_CLASSES)-1:0] class_t;

    // class 0 on vcs 0/1, class 1 on vcs 2/3
    localparam logic [NUM_CLASSES-1:0][NUM_VCS-1:0] CLASS_VC_MASK = {4'b1100, 4'b0011};

endpackage

`default_nettype wire

//--- files.f
common/noc_pkg.sv
common/flit_pkg.sv
hdl/fwft_fifo.sv
input_queue/flit_buffer.sv
input_queue/look_ahead_xy_route.sv
input_queue/ivc_control.sv
input_queue/header_update.sv
input_queue/input_queue_per_port.sv
hdl/input_ports.sv
tb/tb_input_ports.sv

//--- hdl/fwft_fifo.sv
`default_nettype none

module fwft_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      wr_en_i,
    input  wire      rd_en_i,
    input  payload_t din_i,
    output payload_t dout_o,
    output logic     empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             rd_ok;

    assign rd_ok = rd_en_i && (count != '0);   // pop of an empty fifo is dropped

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en_i, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_ptr] <= din_i;
        end
    end

    // head entry always visible
    assign dout_o  = mem[rd_ptr];
    assign empty_o = (count == '0);

endmodule

`default_nettype wire

//--- hdl/input_ports.sv
`default_nettype none

module input_ports (
    input  wire                                                              clk,
    input  wire                                                              reset,
    input  noc_pkg::router_addr_t                                            current_addr_i,
    input  flit_pkg::flit_t    [noc_pkg::NUM_PORTS-1:0]                      flit_in_i,
    input  wire                [noc_pkg::NUM_PORTS-1:0]                      flit_in_we_i,
    input  flit_pkg::sw_ctrl_t [noc_pkg::NUM_PORTS-1:0]                      sw_ctrl_i,
    output flit_pkg::ivc_status_t [noc_pkg::NUM_PORTS-1:0][noc_pkg::NUM_VCS-1:0] ivc_status_o,
    output flit_pkg::flit_t    [noc_pkg::NUM_PORTS-1:0]                      flit_out_o,
    output logic               [noc_pkg::NUM_PORTS-1:0]                      flit_out_valid_o
);

    // one queue per router port, port index sets the own-port mask
    for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_port
        input_queue_per_port #(.PORT_NUM(p)) u_input_queue (
            .clk            (clk),
            .reset          (reset),
            .current_addr_i (current_addr_i),
            .flit_i         (flit_in_i[p]),
            .flit_we_i      (flit_in_we_i[p]),
            .sw_ctrl_i      (sw_ctrl_i[p]),
            .status_o       (ivc_status_o[p]),
            .flit_o         (flit_out_o[p]),
            .flit_valid_o   (flit_out_valid_o[p])
        );
    end

endmodule

`default_nettype wire

//--- input_queue/flit_buffer.sv
`default_nettype none

module flit_buffer (
    input  wire               clk,
    input  wire               reset,
    input  wire               wr_en_i,
    input  noc_pkg::vc_mask_t wr_vc_i,
    input  flit_pkg::flit_t   din_i,
    input  noc_pkg::vc_mask_t rd_vc_i,
    output flit_pkg::flit_t   dout_o,
    output logic              dout_valid_o,
    output noc_pkg::vc_mask_t not_empty_o
);

    localparam int PTR_W = $clog2(noc_pkg::VC_DEPTH);
    localparam int VC_W  = $clog2(noc_pkg::NUM_VCS);

    // vc index in the upper address bits
    flit_pkg::flit_t mem [noc_pkg::NUM_VCS * noc_pkg::VC_DEPTH];

    logic [noc_pkg::NUM_VCS-1:0][PTR_W-1:0] wr_ptr;
    logic [noc_pkg::NUM_VCS-1:0][PTR_W-1:0] rd_ptr;
    logic [noc_pkg::NUM_VCS-1:0][PTR_W:0]   count;
    logic [VC_W-1:0]                        wr_idx;
    logic [VC_W-1:0]                        rd_idx;
    noc_pkg::vc_mask_t                      wr_ok;
    noc_pkg::vc_mask_t                      rd_ok;

    always_comb begin
        wr_idx = '0;
        rd_idx = '0;
        for (int v = 0; v < noc_pkg::NUM_VCS; v++) begin
            if (wr_vc_i[v]) wr_idx = VC_W'(v);
            if (rd_vc_i[v]) rd_idx = VC_W'(v);
            not_empty_o[v] = (count[v] != '0);
        end
    end

    assign wr_ok = wr_en_i ? wr_vc_i : '0;
    assign rd_ok = rd_vc_i & not_empty_o;   // grant on empty vc ignored

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            dout_valid_o <= 1'b0;
        end else begin
            dout_valid_o <= |rd_ok;
            for (int v = 0; v < noc_pkg::NUM_VCS; v++) begin
                if (wr_ok[v]) wr_ptr[v] <= wr_ptr[v] + 1'b1;   // depth is a power of two
                if (rd_ok[v]) rd_ptr[v] <= rd_ptr[v] + 1'b1;
                count[v] <= count[v] + (PTR_W+1)'(wr_ok[v]) - (PTR_W+1)'(rd_ok[v]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[{wr_idx, wr_ptr[wr_idx]}] <= din_i;
        end
        if (|rd_ok) begin
            dout_o <= mem[{rd_idx, rd_ptr[rd_idx]}];
        end
    end

endmodule

`default_nettype wire

//--- input_queue/header_update.sv
`default_nettype none

module header_update (
    input  wire                                        clk,
    input  wire                                        reset,
    input  noc_pkg::vc_mask_t                          ivc_grant_i,
    input  noc_pkg::vc_mask_t  [noc_pkg::NUM_VCS-1:0]  assigned_ovc_i,
    input  noc_pkg::port_num_t [noc_pkg::NUM_VCS-1:0]  lk_port_i,
    input  flit_pkg::flit_t                            buf_flit_i,
    input  wire                                        buf_valid_i,
    output flit_pkg::flit_t                            flit_o,
    output logic                                       flit_valid_o
);

    noc_pkg::vc_mask_t     ovc_sel;
    noc_pkg::port_num_t    lk_sel;
    noc_pkg::vc_mask_t     ovc_q;
    noc_pkg::port_num_t    lk_q;
    flit_pkg::hdr_fields_t hdr;

    // grant is one hot, so an or-mux is enough
    always_comb begin
        ovc_sel = '0;
        lk_sel  = '0;
        for (int v = 0; v < noc_pkg::NUM_VCS; v++) begin
            if (ivc_grant_i[v]) begin
                ovc_sel |= assigned_ovc_i[v];
                lk_sel  |= lk_port_i[v];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ovc_q <= '0;
            lk_q  <= noc_pkg::PORT_LOCAL;
        end else if (|ivc_grant_i) begin
            ovc_q <= ovc_sel;
            lk_q  <= lk_sel;
        end
    end

    always_comb begin
        hdr           = flit_pkg::hdr_fields_t'(buf_flit_i.payload);
        hdr.dest_port = lk_q;   // next router's output port
        flit_o        = buf_flit_i;
        if (buf_flit_i.hdr) begin
            flit_o.payload = hdr;
            flit_o.vc      = ovc_q;
        end
    end

    assign flit_valid_o = buf_valid_i;

endmodule

`default_nettype wire

//--- input_queue/input_queue_per_port.sv
`default_nettype none

module input_queue_per_port #(
    parameter int PORT_NUM = 0
) (
    input  wire                                           clk,
    input  wire                                           reset,
    input  noc_pkg::router_addr_t                         current_addr_i,
    input  flit_pkg::flit_t                               flit_i,
    input  wire                                           flit_we_i,
    input  flit_pkg::sw_ctrl_t                            sw_ctrl_i,
    output flit_pkg::ivc_status_t [noc_pkg::NUM_VCS-1:0]  status_o,
    output flit_pkg::flit_t                               flit_o,
    output logic                                          flit_valid_o
);

    flit_pkg::hdr_fields_t                        hdr_in;
    noc_pkg::vc_mask_t                            flit_wr;
    noc_pkg::vc_mask_t                            hdr_wr;
    noc_pkg::port_num_t                           lk_port_new;
    noc_pkg::port_num_t  [noc_pkg::NUM_VCS-1:0]   lk_port_q;
    noc_pkg::vc_mask_t                            not_empty;
    noc_pkg::vc_mask_t                            status_tail;
    noc_pkg::port_mask_t [noc_pkg::NUM_VCS-1:0]   status_dest;
    noc_pkg::vc_mask_t   [noc_pkg::NUM_VCS-1:0]   status_ovcs;
    flit_pkg::flit_t                              buf_flit;
    logic                                         buf_valid;

    assign hdr_in  = flit_pkg::hdr_fields_t'(flit_i.payload);
    assign flit_wr = flit_we_i ? flit_i.vc : '0;   // per-vc write strobes
    assign hdr_wr  = flit_i.hdr ? flit_wr : '0;

    flit_buffer u_flit_buffer (
        .clk          (clk),
        .reset        (reset),
        .wr_en_i      (flit_we_i),
        .wr_vc_i      (flit_i.vc),
        .din_i        (flit_i),
        .rd_vc_i      (sw_ctrl_i.ivc_grant),
        .dout_o       (buf_flit),
        .dout_valid_o (buf_valid),
        .not_empty_o  (not_empty)
    );

    look_ahead_xy_route u_lk_route (
        .clk            (clk),
        .reset          (reset),
        .current_addr_i (current_addr_i),
        .dest_port_i    (hdr_in.dest_port),
        .dest_addr_i    (hdr_in.dest_addr),
        .lk_port_o      (lk_port_new)
    );

    ivc_control #(.PORT_NUM(PORT_NUM)) u_ivc_control (
        .clk           (clk),
        .reset         (reset),
        .flit_wr_i     (flit_wr),
        .hdr_wr_i      (hdr_wr),
        .tail_i        (flit_i.tail),
        .class_i       (hdr_in.class_id),
        .dest_port_i   (hdr_in.dest_port),
        .lk_port_i     (lk_port_new),
        .ivc_grant_i   (sw_ctrl_i.ivc_grant),
        .reset_ivc_i   (sw_ctrl_i.reset_ivc),
        .lk_port_o     (lk_port_q),
        .status_tail_o (status_tail),
        .status_dest_o (status_dest),
        .status_ovcs_o (status_ovcs)
    );

    header_update u_header_update (
        .clk            (clk),
        .reset          (reset),
        .ivc_grant_i    (sw_ctrl_i.ivc_grant),
        .assigned_ovc_i (sw_ctrl_i.assigned_ovc),
        .lk_port_i      (lk_port_q),
        .buf_flit_i     (buf_flit),
        .buf_valid_i    (buf_valid),
        .flit_o         (flit_o),
        .flit_valid_o   (flit_valid_o)
    );

    for (genvar v = 0; v < noc_pkg::NUM_VCS; v++) begin : g_status
        assign status_o[v] = '{
            request:        not_empty[v],
            tail:           status_tail[v],
            dest_port:      status_dest[v],
            candidate_ovcs: status_ovcs[v]
        };
    end

endmodule

`default_nettype wire

//--- input_queue/ivc_control.sv
`default_nettype none

module ivc_control #(
    parameter int PORT_NUM = 0
) (
    input  wire                                                clk,
    input  wire                                                reset,
    input  noc_pkg::vc_mask_t                                  flit_wr_i,
    input  noc_pkg::vc_mask_t                                  hdr_wr_i,
    input  wire                                                tail_i,
    input  wire                                                class_i,
    input  noc_pkg::port_num_t                                 dest_port_i,
    input  noc_pkg::port_num_t                                 lk_port_i,
    input  noc_pkg::vc_mask_t                                  ivc_grant_i,
    input  noc_pkg::vc_mask_t                                  reset_ivc_i,
    output noc_pkg::port_num_t  [noc_pkg::NUM_VCS-1:0]         lk_port_o,
    output noc_pkg::vc_mask_t                                  status_tail_o,
    output noc_pkg::port_mask_t [noc_pkg::NUM_VCS-1:0]         status_dest_o,
    output noc_pkg::vc_mask_t   [noc_pkg::NUM_VCS-1:0]         status_ovcs_o
);

    noc_pkg::vc_mask_t  hdr_wr_d;   // look-ahead result lands one edge late
    noc_pkg::vc_mask_t  tail_q;
    noc_pkg::vc_mask_t  tail_empty;
    noc_pkg::vc_mask_t  class_empty;
    noc_pkg::vc_mask_t  dest_empty;
    noc_pkg::class_t    class_q [noc_pkg::NUM_VCS];
    noc_pkg::port_num_t dest_q  [noc_pkg::NUM_VCS];

    // drop own port from the 5-bit one hot
    function automatic noc_pkg::port_mask_t to_port_mask(noc_pkg::port_num_t port);
        logic [noc_pkg::NUM_PORTS-1:0] onehot;
        noc_pkg::port_mask_t           mask;
        onehot = noc_pkg::NUM_PORTS'(1) << port;
        for (int k = 0; k < noc_pkg::NUM_PORTS - 1; k++) begin
            mask[k] = (k < PORT_NUM) ? onehot[k] : onehot[k+1];
        end
        return mask;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hdr_wr_d <= '0;
        end else begin
            hdr_wr_d <= hdr_wr_i;
        end
    end

    for (genvar v = 0; v < noc_pkg::NUM_VCS; v++) begin : g_vc
        // one entry per flit
        fwft_fifo #(.payload_t(logic), .DEPTH(noc_pkg::VC_DEPTH)) u_tail_fifo (
            .clk     (clk),
            .reset   (reset),
            .wr_en_i (flit_wr_i[v]),
            .rd_en_i (ivc_grant_i[v]),
            .din_i   (tail_i),
            .dout_o  (tail_q[v]),
            .empty_o (tail_empty[v])
        );

        // one entry per packet, popped on release
        fwft_fifo #(.payload_t(noc_pkg::class_t), .DEPTH(noc_pkg::VC_DEPTH)) u_class_fifo (
            .clk     (clk),
            .reset   (reset),
            .wr_en_i (hdr_wr_i[v]),
            .rd_en_i (reset_ivc_i[v]),
            .din_i   (class_i),
            .dout_o  (class_q[v]),
            .empty_o (class_empty[v])
        );

        fwft_fifo #(.payload_t(noc_pkg::port_num_t), .DEPTH(noc_pkg::VC_DEPTH)) u_dest_fifo (
            .clk     (clk),
            .reset   (reset),
            .wr_en_i (hdr_wr_i[v]),
            .rd_en_i (reset_ivc_i[v]),
            .din_i   (dest_port_i),
            .dout_o  (dest_q[v]),
            .empty_o (dest_empty[v])
        );

        fwft_fifo #(.payload_t(noc_pkg::port_num_t), .DEPTH(noc_pkg::VC_DEPTH)) u_lk_fifo (
            .clk     (clk),
            .reset   (reset),
            .wr_en_i (hdr_wr_d[v]),
            .rd_en_i (reset_ivc_i[v]),
            .din_i   (lk_port_i),
            .dout_o  (lk_port_o[v]),
            .empty_o ()
        );

        assign status_tail_o[v] = tail_q[v] & ~tail_empty[v];
        assign status_dest_o[v] = dest_empty[v] ? '0 : to_port_mask(dest_q[v]);
        assign status_ovcs_o[v] = class_empty[v] ? '0 : noc_pkg::CLASS_VC_MASK[class_q[v]];
    end

endmodule

`default_nettype wire

//--- input_queue/look_ahead_xy_route.sv
`default_nettype none

module look_ahead_xy_route (
    input  wire                   clk,
    input  wire                   reset,
    input  noc_pkg::router_addr_t current_addr_i,
    input  noc_pkg::port_num_t    dest_port_i,
    input  noc_pkg::router_addr_t dest_addr_i,
    output noc_pkg::port_num_t    lk_port_o
);

    noc_pkg::router_addr_t next_addr;
    noc_pkg::port_num_t    lk_next;

    // neighbour the flit leaves to
    always_comb begin
        next_addr = current_addr_i;
        case (dest_port_i)
            noc_pkg::PORT_EAST:  next_addr.x = current_addr_i.x + 1'b1;
            noc_pkg::PORT_NORTH: next_addr.y = current_addr_i.y - 1'b1;
            noc_pkg::PORT_WEST:  next_addr.x = current_addr_i.x - 1'b1;
            noc_pkg::PORT_SOUTH: next_addr.y = current_addr_i.y + 1'b1;
            default:             next_addr   = current_addr_i;
        endcase
    end

    // xy from the next router, x first
    always_comb begin
        if (dest_port_i == noc_pkg::PORT_LOCAL) begin
            lk_next = noc_pkg::PORT_LOCAL;   // ejects here
        end else if (dest_addr_i.x > next_addr.x) begin
            lk_next = noc_pkg::PORT_EAST;
        end else if (dest_addr_i.x < next_addr.x) begin
            lk_next = noc_pkg::PORT_WEST;
        end else if (dest_addr_i.y < next_addr.y) begin
            lk_next = noc_pkg::PORT_NORTH;
        end else if (dest_addr_i.y > next_addr.y) begin
            lk_next = noc_pkg::PORT_SOUTH;
        end else begin
            lk_next = noc_pkg::PORT_LOCAL;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lk_port_o <= noc_pkg::PORT_LOCAL;
        end else begin
            lk_port_o <= lk_next;
        end
    end

endmodule

`default_nettype wire

//--- tb/input_ports_tests.txt
// group addr port vc len class dest_port dest_addr exp_mask exp_ovcs exp_lk_port assigned_ovc
// one hex digit each, lines of one group share the address and are written together
0500301F1312
151211314C04
2A21204B8301
2A21210A1C08
2A3341284C24
3601201E1311
360231478C08
361040304322
362321061C04
3620101A2301
363231244C28
3630204F8312
364130338342
3641101A2301
401321438C48
4042211C2C14

//--- tb/tb_input_ports.sv
`default_nettype none

module tb_input_ports;

    timeunit 1ns;
    timeprecision 1ps;

    logic                                                                  clk;
    logic                                                                  reset;
    noc_pkg::router_addr_t                                                 current_addr;
    flit_pkg::flit_t       [noc_pkg::NUM_PORTS-1:0]                        flit_in;
    logic                  [noc_pkg::NUM_PORTS-1:0]                        flit_in_we;
    flit_pkg::sw_ctrl_t    [noc_pkg::NUM_PORTS-1:0]                        sw_ctrl;
    flit_pkg::ivc_status_t [noc_pkg::NUM_PORTS-1:0][noc_pkg::NUM_VCS-1:0]  ivc_status;
    flit_pkg::flit_t       [noc_pkg::NUM_PORTS-1:0]                        flit_out;
    logic                  [noc_pkg::NUM_PORTS-1:0]                        flit_out_valid;

    logic [47:0] tests [0:31];   // twelve hex columns per packet
    int          num_tests;
    int          cycle_count;
    int          cycle_limit;
    int          err_count;
    int          n_pass;
    int          n_fail;
    int          test_err  [0:31];
    logic        test_done [0:31];
    logic [31:0] lfsr_state;

    // flits of the current group per input port in write order
    flit_pkg::flit_t stream_in  [noc_pkg::NUM_PORTS][16];
    flit_pkg::flit_t stream_exp [noc_pkg::NUM_PORTS][16];
    int              stream_tid [noc_pkg::NUM_PORTS][16];
    int              stream_len [noc_pkg::NUM_PORTS];

    // model of what each vc holds
    flit_pkg::flit_t vc_exp   [noc_pkg::NUM_PORTS][noc_pkg::NUM_VCS][8];
    int              vc_tid   [noc_pkg::NUM_PORTS][noc_pkg::NUM_VCS][8];
    int              vc_wr    [noc_pkg::NUM_PORTS][noc_pkg::NUM_VCS];
    int              vc_rd    [noc_pkg::NUM_PORTS][noc_pkg::NUM_VCS];
    int              pkt_test [noc_pkg::NUM_PORTS][noc_pkg::NUM_VCS][4];
    int              pkt_wr   [noc_pkg::NUM_PORTS][noc_pkg::NUM_VCS];
    int              pkt_rd   [noc_pkg::NUM_PORTS][noc_pkg::NUM_VCS];
    int              ord_vc   [noc_pkg::NUM_PORTS][16];   // vc of each flit in age order
    int              ord_wr   [noc_pkg::NUM_PORTS];
    int              ord_rd   [noc_pkg::NUM_PORTS];
    flit_pkg::flit_t pend_flit  [noc_pkg::NUM_PORTS];
    logic            pend_valid [noc_pkg::NUM_PORTS];
    int              pend_test  [noc_pkg::NUM_PORTS];

    input_ports u_input_ports (
        .clk              (clk),
        .reset            (reset),
        .current_addr_i   (current_addr),
        .flit_in_i        (flit_in),
        .flit_in_we_i     (flit_in_we),
        .sw_ctrl_i        (sw_ctrl),
        .ivc_status_o     (ivc_status),
        .flit_out_o       (flit_out),
        .flit_out_valid_o (flit_out_valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // column 0 is the leftmost hex digit
    function automatic logic [3:0] col(input int t, input int c);
        return tests[t][47-4*c -: 4];
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic report_value(input string sig, input logic [37:0] exp,
                                input logic [37:0] got, input int t);
        $display("ERR %s exp %h got %h (test %0d, %0t)", sig, exp, got, t, $time);
        err_count++;
        if (t >= 0) test_err[t]++;
    endtask

    task automatic finish_test(input int t);
        test_done[t] = 1'b1;
        $display("test %0d: port %0d vc %0d, %0d flits, %s", t, col(t, 2), col(t, 3),
                 col(t, 4), (test_err[t] == 0) ? "ok" : "failed");
        if (test_err[t] == 0) n_pass++;
        else n_fail++;
    endtask

    task automatic clear_model();
        for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
            stream_len[p] = 0;
            ord_wr[p]     = 0;
            ord_rd[p]     = 0;
            for (int v = 0; v < noc_pkg::NUM_VCS; v++) begin
                vc_wr[p][v]  = 0;
                vc_rd[p][v]  = 0;
                pkt_wr[p][v] = 0;
                pkt_rd[p][v] = 0;
            end
        end
    endtask

    // outputs and status after the last edge against the model
    task automatic check_state();
        int         t;
        logic       exp_req;
        logic       exp_tail;
        logic [3:0] exp_dest;
        logic [3:0] exp_ovcs;
        for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
            if (pend_valid[p]) begin
                if (flit_out_valid[p] !== 1'b1) begin
                    report_value($sformatf("flit_out_valid_o[%0d]", p), 38'h1,
                                 38'(flit_out_valid[p]), pend_test[p]);
                end else begin
                    if (flit_out[p] !== pend_flit[p]) begin
                        report_value($sformatf("flit_out_o[%0d]", p), pend_flit[p],
                                     flit_out[p], pend_test[p]);
                    end
                    if (pend_flit[p].tail) finish_test(pend_test[p]);
                end
                pend_valid[p] = 1'b0;
            end else if (flit_out_valid[p] !== 1'b0) begin
                report_value($sformatf("flit_out_valid_o[%0d]", p), 38'h0,
                             38'(flit_out_valid[p]), -1);
            end
            for (int v = 0; v < noc_pkg::NUM_VCS; v++) begin
                t        = -1;
                exp_dest = '0;
                exp_ovcs = '0;
                if (pkt_rd[p][v] < pkt_wr[p][v]) begin
                    t        = pkt_test[p][v][pkt_rd[p][v]];
                    exp_dest = col(t, 8);
                    exp_ovcs = col(t, 9);
                end
                exp_req  = (vc_rd[p][v] < vc_wr[p][v]);
                exp_tail = exp_req ? vc_exp[p][v][vc_rd[p][v]].tail : 1'b0;
                if (ivc_status[p][v].request !== exp_req) begin
                    report_value($sformatf("ivc_status_o[%0d][%0d].request", p, v),
                                 38'(exp_req), 38'(ivc_status[p][v].request), t);
                end
                if (ivc_status[p][v].tail !== exp_tail) begin
                    report_value($sformatf("ivc_status_o[%0d][%0d].tail", p, v),
                                 38'(exp_tail), 38'(ivc_status[p][v].tail), t);
                end
                if (ivc_status[p][v].dest_port !== exp_dest) begin
                    report_value($sformatf("ivc_status_o[%0d][%0d].dest_port", p, v),
                                 38'(exp_dest), 38'(ivc_status[p][v].dest_port), t);
                end
                if (ivc_status[p][v].candidate_ovcs !== exp_ovcs) begin
                    report_value($sformatf("ivc_status_o[%0d][%0d].candidate_ovcs", p, v),
                                 38'(exp_ovcs), 38'(ivc_status[p][v].candidate_ovcs), t);
                end
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        check_state();
        flit_in_we = '0;
        flit_in    = '0;
        sw_ctrl    = '0;
    endtask

    task automatic run_group(input int first, input int last);
        flit_pkg::flit_t f;
        flit_pkg::flit_t e;
        logic [31:0]     bits;
        logic [3:0]      cls;
        logic [3:0]      dst;
        logic [3:0]      lk;
        int              p;
        int              v;
        int              i;
        int              pos [noc_pkg::NUM_PORTS];
        logic            busy;
        clear_model();
        current_addr = col(first, 1);
        for (int t = first; t < last; t++) begin
            p = col(t, 2);
            for (int k = 0; k < col(t, 4); k++) begin
                f.hdr  = (k == 0);
                f.tail = (k == col(t, 4) - 1);
                f.vc   = 4'b0001 << col(t, 3);
                if (k == 0) begin
                    take_bits(24, bits);   // src address and data
                    cls       = col(t, 5);
                    dst       = col(t, 6);
                    f.payload = {cls[0], dst[2:0], col(t, 7), bits[23:0]};
                end else begin
                    take_bits(32, bits);
                    f.payload = bits;
                end
                e = f;
                if (f.hdr) begin
                    lk               = col(t, 10);
                    e.payload[30:28] = lk[2:0];   // look-ahead port replaces destination
                    e.vc             = col(t, 11);
                end
                stream_in[p][stream_len[p]]  = f;
                stream_exp[p][stream_len[p]] = e;
                stream_tid[p][stream_len[p]] = t;
                stream_len[p]++;
            end
        end
        for (int q = 0; q < noc_pkg::NUM_PORTS; q++) pos[q] = 0;

        busy = 1'b1;
        while (busy) begin
            next_cycle();
            busy = 1'b0;
            for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
                if (pos[q] < stream_len[q]) begin
                    flit_in[q]    = stream_in[q][pos[q]];
                    flit_in_we[q] = 1'b1;
                    v = col(stream_tid[q][pos[q]], 3);
                    vc_exp[q][v][vc_wr[q][v]] = stream_exp[q][pos[q]];
                    vc_tid[q][v][vc_wr[q][v]] = stream_tid[q][pos[q]];
                    vc_wr[q][v]++;
                    if (stream_in[q][pos[q]].hdr) begin
                        pkt_test[q][v][pkt_wr[q][v]] = stream_tid[q][pos[q]];
                        pkt_wr[q][v]++;
                    end
                    ord_vc[q][ord_wr[q]] = v;
                    ord_wr[q]++;
                    pos[q]++;
                    busy = 1'b1;
                end
            end
        end

        // allocator model grants the oldest flit of each port first
        busy = 1'b1;
        while (busy) begin
            next_cycle();
            busy = 1'b0;
            for (int q = 0; q < noc_pkg::NUM_PORTS; q++) begin
                if (ord_rd[q] < ord_wr[q]) begin
                    v = ord_vc[q][ord_rd[q]];
                    i = vc_rd[q][v];
                    ord_rd[q]++;
                    vc_rd[q][v]++;
                    sw_ctrl[q].ivc_grant = 4'b0001 << v;
                    if (vc_exp[q][v][i].hdr) begin
                        sw_ctrl[q].assigned_ovc[v] = col(vc_tid[q][v][i], 11);
                    end
                    if (vc_exp[q][v][i].tail) begin
                        sw_ctrl[q].reset_ivc = 4'b0001 << v;   // release with the tail
                        pkt_rd[q][v]++;
                    end
                    pend_flit[q]  = vc_exp[q][v][i];
                    pend_test[q]  = vc_tid[q][v][i];
                    pend_valid[q] = 1'b1;
                    busy = 1'b1;
                end
            end
        end
        for (int t = first; t < last; t++) begin
            if (!test_done[t]) begin
                $display("test %0d: tail flit never came out of the port", t);
                err_count++;
                n_fail++;
            end
        end
    endtask

    initial begin
        int t;
        int first;
        clk          = 1'b0;
        reset        = 1'b1;
        current_addr = '0;
        flit_in      = '0;
        flit_in_we   = '0;
        sw_ctrl      = '0;
        cycle_count  = 0;
        err_count    = 0;
        n_pass       = 0;
        n_fail       = 0;
        lfsr_state   = 32'h66b3_7a4d;
        for (int k = 0; k < 32; k++) begin
            tests[k]     = '0;
            test_err[k]  = 0;
            test_done[k] = 1'b0;
        end
        for (int p = 0; p < noc_pkg::NUM_PORTS; p++) pend_valid[p] = 1'b0;
        clear_model();
        $readmemh("tb/input_ports_tests.txt", tests);
        num_tests = 0;
        while (num_tests < 32 && col(num_tests, 4) != 4'h0) num_tests++;
        cycle_limit = 40 * num_tests + 16;
        if (num_tests == 0) begin
            $display("no test lines could be loaded from the data file");
            err_count++;
        end

        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        repeat (4) next_cycle();   // idle cycles with no output

        t = 0;
        while (t < num_tests) begin
            first = t;
            while (t < num_tests && col(t, 0) == col(first, 0)) t++;
            run_group(first, t);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, n_pass, n_fail, err_count);
        if (err_count == 0 && n_fail == 0 && n_pass == num_tests) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
